// ==== design/alu_32.sv ====
/*
 * alu_32
 * combinational 32-bit ALU, arithmetic, logic, set-less-than, shifts
 * and lui, with signed overflow for add and sub
 */
`timescale 1ns/1ps
`default_nettype none

module alu_32 (
  input  mips_isa_pkg::word_t     a,
  input  mips_isa_pkg::word_t     b,
  input  logic [4:0]              shamt,
  input  mips_ctrl_pkg::alu_op_t  op,
  output mips_isa_pkg::word_t     result,
  output logic                    overflow
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  word_t sum;
  word_t diff;
  logic  add_ovf;
  logic  sub_ovf;

  assign sum  = a + b;
  assign diff = a - b;

  // same-sign operands giving a result of the other sign
  assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
  // differing signs where the result follows b
  assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

  always_comb begin
    result   = '0;
    overflow = 1'b0;
    case (op)
      ALU_ADD: begin
        result   = sum;
        overflow = add_ovf;
      end
      ALU_SUB: begin
        result   = diff;
        overflow = sub_ovf;
      end
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
      // shifts act on rt, as in MIPS
      ALU_SLL: result = b << shamt;
      ALU_SRL: result = b >> shamt;
      ALU_LUI: result = {b[15:0], 16'b0};
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/control_32.sv ====
/*
 * control_32
 * slices the instruction fields and decodes opcode and funct into
 * the control word, flagging codes outside the supported subset
 */
`timescale 1ns/1ps
`default_nettype none

module control_32 (
  input  mips_isa_pkg::word_t      instruction,
  output mips_ctrl_pkg::alu_op_t   alu_op,
  output logic                     alu_src_imm,
  output logic                     zero_ext,
  output mips_ctrl_pkg::reg_dst_t  reg_dst,
  output logic                     reg_write,
  output logic                     mem_write,
  output mips_ctrl_pkg::wb_sel_t   wb_sel,
  output logic                     may_overflow,
  output logic                     illegal,
  output mips_isa_pkg::reg_addr_t  rs,
  output mips_isa_pkg::reg_addr_t  rt,
  output mips_isa_pkg::reg_addr_t  rd,
  output logic [4:0]               shamt,
  output logic [15:0]              immediate
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  opcode_t opcode;
  funct_t  funct;

  assign opcode    = opcode_t'(instruction[31:26]);
  assign funct     = funct_t'(instruction[5:0]);
  assign rs        = instruction[25:21];
  assign rt        = instruction[20:16];
  assign rd        = instruction[15:11];
  assign shamt     = instruction[10:6];
  assign immediate = instruction[15:0];

  always_comb begin
    // defaults describe a no-op
    alu_op       = ALU_ADD;
    alu_src_imm  = 1'b0;
    zero_ext     = 1'b0;
    reg_dst      = DST_RT;
    reg_write    = 1'b0;
    mem_write    = 1'b0;
    wb_sel       = WB_ALU;
    may_overflow = 1'b0;
    illegal      = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        reg_dst   = DST_RD;
        reg_write = 1'b1;
        case (funct)
          FN_ADD: begin
            alu_op       = ALU_ADD;
            may_overflow = 1'b1;
          end
          FN_SUB: begin
            alu_op       = ALU_SUB;
            may_overflow = 1'b1;
          end
          FN_AND: alu_op = ALU_AND;
          FN_OR:  alu_op = ALU_OR;
          FN_SLT: alu_op = ALU_SLT;
          FN_SLL: alu_op = ALU_SLL;
          FN_SRL: alu_op = ALU_SRL;
          default: begin
            reg_write = 1'b0;
            illegal   = 1'b1;
          end
        endcase
      end
      OP_ADDI: begin
        alu_src_imm  = 1'b1;
        reg_write    = 1'b1;
        may_overflow = 1'b1;
      end
      OP_ANDI: begin
        alu_op      = ALU_AND;
        alu_src_imm = 1'b1;
        zero_ext    = 1'b1;
        reg_write   = 1'b1;
      end
      OP_ORI: begin
        alu_op      = ALU_OR;
        alu_src_imm = 1'b1;
        zero_ext    = 1'b1;
        reg_write   = 1'b1;
      end
      OP_LUI: begin
        alu_op      = ALU_LUI;
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
      end
      OP_LW: begin
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        wb_sel      = WB_MEM;
      end
      OP_SW: begin
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      // OP_ILLEGAL and any unlisted opcode land here
      default: illegal = 1'b1;
    endcase
  end

  // a known instruction yields a known control word
  always_comb begin
    if (!$isunknown(instruction)) begin
      assert (!$isunknown({alu_op, alu_src_imm, zero_ext, reg_dst, reg_write,
                           mem_write, wb_sel, may_overflow, illegal}))
        else $error("control_32: bad control word for %h", instruction);
    end
  end

endmodule

`default_nettype wire

// ==== design/data_memory.sv ====
/*
 * data_memory
 * word-addressed data RAM, combinational read and clocked write,
 * depth of 2**MEM_ADDR_WIDTH words
 */
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic                       clock,
  input  logic                       rst,
  input  logic [MEM_ADDR_WIDTH-1:0]  addr,
  input  mips_isa_pkg::word_t        write_data,
  input  logic                       write_en,
  output mips_isa_pkg::word_t        read_data
);
  import mips_isa_pkg::*;

  localparam int DEPTH = 2 ** MEM_ADDR_WIDTH;

  word_t mem [DEPTH];

  always_ff @(posedge clock) begin
    if (rst) begin
      mem <= '{default: '0};
    end else if (write_en) begin
      mem[addr] <= write_data;
    end
  end

  // lw sees the word straight away in the same cycle
  assign read_data = mem[addr];

  // a store never goes out with an undefined address
  assert property (@(posedge clock) disable iff (rst)
    write_en |-> !$isunknown(addr))
    else $error("data_memory: store to unknown address");

endmodule

`default_nettype wire

// ==== design/debug_apb.sv ====
/*
 * debug_apb
 * APB slave for run control, sticky status, retired-instruction count
 * and a read window onto the register file
 */
`timescale 1ns/1ps
`default_nettype none

module debug_apb (
  input  logic                     clock,
  input  logic                     rst,
  input  logic [11:0]              paddr,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  mips_isa_pkg::word_t      pwdata,
  output mips_isa_pkg::word_t      prdata,
  output logic                     pready,
  output logic                     pslverr,
  input  logic                     execute,
  input  logic                     illegal,
  input  logic                     overflow,
  output logic                     run,
  output mips_isa_pkg::reg_addr_t  dbg_addr,
  input  mips_isa_pkg::word_t      dbg_data
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  status_t status;
  status_t set_mask;
  status_t clr_mask;
  word_t   retired;
  word_t   rdata;
  logic    access;
  logic    in_window;
  logic    mapped;

  assign access    = psel && penable;
  // 0x80..0xfc, word aligned
  assign in_window = (paddr[11:7] == DBG_REG_BASE[11:7]) && (paddr[1:0] == 2'b00);
  assign mapped    = (paddr == DBG_CTRL) || (paddr == DBG_STATUS) ||
                     (paddr == DBG_RETIRED) || in_window;
  assign dbg_addr  = paddr[6:2];

  always_comb begin
    set_mask.illegal  = execute && illegal;
    set_mask.overflow = execute && overflow;
    clr_mask          = (access && pwrite && (paddr == DBG_STATUS)) ?
                        status_t'(pwdata[1:0]) : '0;
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      run     <= 1'b0;
      status  <= '0;
      retired <= '0;
    end else begin
      if (access && pwrite && (paddr == DBG_CTRL)) begin
        run <= pwdata[0];
      end
      // a new event wins over a clear in the same cycle
      status <= (status & ~clr_mask) | set_mask;
      if (execute) begin
        retired <= retired + 1'b1;
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (paddr)
      DBG_CTRL:    rdata = {31'b0, run};
      DBG_STATUS:  rdata = {30'b0, status};
      DBG_RETIRED: rdata = retired;
      default:     if (in_window) rdata = dbg_data;
    endcase
  end

  // no wait states
  assign pready  = 1'b1;
  assign prdata  = (access && !pwrite) ? rdata : '0;
  assign pslverr = access && !mapped;

  // every access phase follows a setup phase with psel already high
  assert property (@(posedge clock) disable iff (rst) $rose(penable) |-> $past(psel))
    else $error("debug_apb: penable rose without a setup phase");

endmodule

`default_nettype wire

// ==== design/mips_cpu.sv ====
/*
 * mips_cpu
 * single-cycle MIPS execution core fed one instruction per cycle,
 * with decode, register file, ALU, data memory and an APB debug block
 */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu #(
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic                 clock,
  input  logic                 rst,
  input  mips_isa_pkg::word_t  instruction,
  input  logic                 instr_valid,
  input  logic [11:0]          paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  mips_isa_pkg::word_t  pwdata,
  output mips_isa_pkg::word_t  prdata,
  output logic                 pready,
  output logic                 pslverr
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  alu_op_t   alu_op;
  reg_dst_t  reg_dst;
  wb_sel_t   wb_sel;
  logic      alu_src_imm, zero_ext, reg_write, mem_write, may_overflow, illegal;
  reg_addr_t rs, rt, rd, dbg_addr, write_addr;
  logic [4:0]  shamt;
  logic [15:0] immediate;
  word_t     rs_data, rt_data, dbg_data, imm_ext, alu_b, alu_result, read_data, write_data;
  logic      alu_overflow, ovf, run, execute, reg_we, mem_we;

  control_32 control_inst (
    .instruction(instruction), .alu_op(alu_op), .alu_src_imm(alu_src_imm),
    .zero_ext(zero_ext), .reg_dst(reg_dst), .reg_write(reg_write),
    .mem_write(mem_write), .wb_sel(wb_sel), .may_overflow(may_overflow),
    .illegal(illegal), .rs(rs), .rt(rt), .rd(rd), .shamt(shamt), .immediate(immediate)
  );

  // andi and ori take the immediate unsigned
  assign imm_ext    = zero_ext ? {16'b0, immediate} : {{16{immediate[15]}}, immediate};
  assign alu_b      = alu_src_imm ? imm_ext : rt_data;
  assign write_addr = (reg_dst == DST_RD) ? rd : rt;
  assign write_data = (wb_sel == WB_MEM) ? read_data : alu_result;

  // overflow only counts for add, sub and addi
  assign ovf     = alu_overflow && may_overflow;
  assign execute = instr_valid && run;
  assign reg_we  = execute && reg_write && !illegal && !ovf;
  assign mem_we  = execute && mem_write && !illegal && !ovf;

  rf_32 rf_inst (
    .clock(clock), .rst(rst), .rs_addr(rs), .rt_addr(rt), .dbg_addr(dbg_addr),
    .write_addr(write_addr), .write_data(write_data), .write_en(reg_we),
    .rs_data(rs_data), .rt_data(rt_data), .dbg_data(dbg_data)
  );

  alu_32 alu_inst (
    .a(rs_data), .b(alu_b), .shamt(shamt), .op(alu_op),
    .result(alu_result), .overflow(alu_overflow)
  );

  // byte address to word address, wrapping at the memory depth
  data_memory #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) data_memory_inst (
    .clock(clock), .rst(rst), .addr(alu_result[MEM_ADDR_WIDTH+1:2]),
    .write_data(rt_data), .write_en(mem_we), .read_data(read_data)
  );

  debug_apb debug_inst (
    .clock(clock), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .execute(execute), .illegal(illegal), .overflow(ovf),
    .run(run), .dbg_addr(dbg_addr), .dbg_data(dbg_data)
  );

endmodule

`default_nettype wire

// ==== design/mips_ctrl_pkg.sv ====
/*
 * MIPS control-path definitions
 * ALU operations, write-back and destination selects, debug map
 */
`default_nettype none

package mips_ctrl_pkg;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
  } alu_op_t;

  typedef enum logic {WB_ALU, WB_MEM} wb_sel_t;

  typedef enum logic {DST_RT, DST_RD} reg_dst_t;

  // sticky flags as seen at DBG_STATUS
  typedef struct packed {
    logic illegal;
    logic overflow;
  } status_t;

  // debug register offsets on the APB side
  localparam logic [11:0] DBG_CTRL     = 12'h000;
  localparam logic [11:0] DBG_STATUS   = 12'h004;
  localparam logic [11:0] DBG_RETIRED  = 12'h008;
  localparam logic [11:0] DBG_REG_BASE = 12'h080;

endpackage

`default_nettype wire

// ==== design/mips_isa_pkg.sv ====
/*
 * MIPS instruction-set definitions
 * word and field types, opcode and funct codes of the supported subset
 */
`default_nettype none

package mips_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // primary opcode field, bits 31:26
  typedef enum logic [5:0] {
    OP_RTYPE   = 6'h00,
    OP_ADDI    = 6'h08,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b,
    OP_ILLEGAL = 6'h3f
  } opcode_t;

  // funct field of R-type, bits 5:0
  typedef enum logic [5:0] {
    FN_SLL = 6'h00,
    FN_SRL = 6'h02,
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_t;

  localparam int NUM_REGS = 32;

endpackage

`default_nettype wire

// ==== design/rf_32.sv ====
/*
 * rf_32
 * 32 x 32-bit register file, three asynchronous read ports and one
 * synchronous write port, r0 hard-wired to zero
 */
`timescale 1ns/1ps
`default_nettype none

module rf_32 (
  input  logic                     clock,
  input  logic                     rst,
  input  mips_isa_pkg::reg_addr_t  rs_addr,
  input  mips_isa_pkg::reg_addr_t  rt_addr,
  input  mips_isa_pkg::reg_addr_t  dbg_addr,
  input  mips_isa_pkg::reg_addr_t  write_addr,
  input  mips_isa_pkg::word_t      write_data,
  input  logic                     write_en,
  output mips_isa_pkg::word_t      rs_data,
  output mips_isa_pkg::word_t      rt_data,
  output mips_isa_pkg::word_t      dbg_data
);
  import mips_isa_pkg::*;

  word_t regs [NUM_REGS];

  always_ff @(posedge clock) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (write_en && (write_addr != '0)) begin
      regs[write_addr] <= write_data;
    end
  end

  assign rs_data  = regs[rs_addr];
  assign rt_data  = regs[rt_addr];
  assign dbg_data = regs[dbg_addr];

  // r0 reads zero on every port, whatever was written to it before
  assert property (@(posedge clock) disable iff (rst)
    ((rs_addr != '0) || (rs_data == '0)) && ((rt_addr != '0) || (rt_data == '0)) &&
    ((dbg_addr != '0) || (dbg_data == '0)))
    else $error("rf_32: r0 read back nonzero");

endmodule

`default_nettype wire

// ==== files.f ====
design/mips_isa_pkg.sv
design/mips_ctrl_pkg.sv
design/control_32.sv
design/rf_32.sv
design/alu_32.sv
design/data_memory.sv
design/debug_apb.sv
design/mips_cpu.sv
verif/mips_cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the mips_cpu testbench with Verilator, run it, and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module mips_cpu_tb -o mips_cpu_sim \
  && ./obj_dir/mips_cpu_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Everything OK" sim.log || { echo "no verdict found in sim.log"; exit 1; }
exit 0

// ==== verif/mips_cpu_tb.sv ====
/*
 * mips_cpu testbench
 * replays the testdata records against the core, issuing instructions and
 * APB accesses and checking read words, status flags and slave errors
 */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_tb;
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  logic        clock;
  logic        rst;
  word_t       instruction;
  logic        instr_valid;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  word_t       pwdata;
  word_t       prdata;
  logic        pready;
  logic        pslverr;

  string       kinds [$];
  string       names [$];
  word_t       field_a [$];
  word_t       field_b [$];
  int          pass_count;
  int          fail_count;
  int          cycles;
  int          cycle_limit;
  logic [31:0] rng_state;

  mips_cpu #(.MEM_ADDR_WIDTH(8)) mips_cpu_inst (
    .clock(clock), .rst(rst), .instruction(instruction), .instr_valid(instr_valid),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  always #5 clock = ~clock;

  // limit is zero until the records are loaded
  always @(posedge clock) begin
    cycles = cycles + 1;
    if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual === expected) begin
      pass_count = pass_count + 1;
      $display("ok       %s  %h", name, actual);
    end else begin
      fail_count = fail_count + 1;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_status(input string name, input status_t expected,
                              input status_t actual);
    if (actual === expected) begin
      pass_count = pass_count + 1;
      $display("ok       %s  illegal=%b overflow=%b", name, actual.illegal, actual.overflow);
    end else begin
      fail_count = fail_count + 1;
      $display("MISMATCH %s expected %b actual %b", name, expected, actual);
    end
  endtask

  task automatic check_slave_error(input string name, input logic err);
    if (err === 1'b1) begin
      pass_count = pass_count + 1;
      $display("ok       %s  slave error raised", name);
    end else begin
      fail_count = fail_count + 1;
      $display("FAILED   %s  an unmapped address gave no slave error", name);
    end
  endtask

  task automatic report_failure(input string name, input string what);
    fail_count = fail_count + 1;
    $display("FAILED   %s  %s", name, what);
  endtask

  task automatic load_records();
    int          fd;
    int          count;
    logic        done;
    string       kind;
    string       name;
    string       rest;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen("verif/mips_testdata.txt", "r");
    if (fd == 0) begin
      report_failure("testdata", "could not open the testdata file");
    end else begin
      done = 1'b0;
      while (!done) begin
        count = $fscanf(fd, "%s", kind);
        if (count != 1) begin
          done = 1'b1;
        end else if (kind.substr(0, 0) == "#") begin
          void'($fgets(rest, fd));
        end else begin
          count = $fscanf(fd, "%s %h %h", name, a, b);
          if (count != 3) begin
            report_failure(kind, "malformed record in the testdata file");
            done = 1'b1;
          end else begin
            kinds.push_back(kind);
            names.push_back(name);
            field_a.push_back(a);
            field_b.push_back(b);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // every bus task starts and ends 1 ns after a rising edge
  task automatic issue_instruction(input word_t instr);
    int gap;
    instruction = instr;
    instr_valid = 1'b1;
    @(posedge clock);
    #1;
    instr_valid = 1'b0;
    rng_state = xorshift(rng_state);
    gap = int'(rng_state[1:0]);
    repeat (gap) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic wait_access_ready();
    #4;
    while (!pready) begin
      @(posedge clock);
      #4;
    end
  endtask

  task automatic apb_access(input logic [11:0] addr, input logic write, input word_t data,
                            output word_t rdata, output logic err);
    paddr   = addr;
    pwrite  = write;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clock);
    #1;
    penable = 1'b1;
    wait_access_ready();
    // sampled mid-cycle, away from the rising edges
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  initial begin
    int          i;
    word_t       rdata;
    logic        err;
    logic [11:0] addr;
    clock       = 1'b0;
    rst         = 1'b1;
    instruction = '0;
    instr_valid = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    pass_count  = 0;
    fail_count  = 0;
    cycles      = 0;
    cycle_limit = 0;
    rng_state   = 32'hbc70;
    load_records();
    cycle_limit = kinds.size() * 8 + 50;
    repeat (8) @(posedge clock);
    #1;
    rst = 1'b0;
    for (i = 0; i < kinds.size(); i++) begin
      addr = field_a[i][11:0];
      if (kinds[i] == "I") begin
        issue_instruction(field_a[i]);
      end else if (kinds[i] == "W") begin
        apb_access(addr, 1'b1, field_b[i], rdata, err);
        if (err) begin
          report_failure(names[i], "write to a mapped address gave a slave error");
        end else begin
          $display("write    %s", names[i]);
        end
      end else if (kinds[i] == "R") begin
        apb_access(addr, 1'b0, '0, rdata, err);
        if (err) begin
          report_failure(names[i], "read of a mapped address gave a slave error");
        end else if (addr == DBG_STATUS) begin
          if (rdata[31:2] !== '0) begin
            report_failure(names[i], "status read has bits set above the two flags");
          end else begin
            check_status(names[i], status_t'(field_b[i][1:0]), status_t'(rdata[1:0]));
          end
        end else begin
          check_word(names[i], field_b[i], rdata);
        end
      end else if (kinds[i] == "E") begin
        apb_access(addr, 1'b0, '0, rdata, err);
        check_slave_error(names[i], err);
      end else begin
        report_failure(names[i], "unknown record kind in the testdata file");
      end
    end
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if ((fail_count == 0) && (pass_count > 0)) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/mips_testdata.txt ====
# kind name a b (hex): I instruction unused, W addr data, R addr expected, E addr unused
# addresses are APB offsets, register n sits at 080 + 4n, status is illegal:overflow
I drop_addi 20010005 0
R drop_r1 084 0
W run_on 000 1
I addi_r1 20010005 0
I addi_r2 2022fffd 0
I add_r3 00221820 0
I sub_r4 00412022 0
I slt_r5 0081282a 0
I lui_r6 3c068001 0
I ori_r6 34c6f0f0 0
I andi_r7 30c7ff00 0
I or_r8 00e34025 0
I and_r9 00884824 0
I sll_r10 00035100 0
I srl_r11 00065a02 0
I addi_r0 20000009 0
R read_r4 090 fffffffd
R read_r5 094 1
R read_r6 098 8001f0f0
R read_r9 0a4 f005
R read_r10 0a8 70
R read_r11 0ac 008001f0
R read_r0 080 0
I sw_word4 ac090010 0
I sw_word5 ac060014 0
I lw_word4 8c0c0010 0
I lw_wrap5 8c0d0414 0
R read_r12 0b0 f005
R read_r13 0b4 8001f0f0
I lui_r14 3c0e7fff 0
I add_ovf 01ce7820 0
R read_r15 0bc 0
R status_ovf 004 1
I illegal_op fc000000 0
R status_both 004 3
W clear_status 004 3
R status_clear 004 0
R retired 008 14
E unmapped 00c 0
